/* rtl/bru_cfg_pkg.sv */
/*
 * Sizes and widths shared by the branch unit.
 * The pack tracker, the branch-information store and the top level take these
 * so that every pack id and occupancy count agree on one width.
 */

package bru_cfg_pkg;

    // Number of branch packs that may be in flight between rename and resolve
    localparam int PACK_COUNT = 16;

    // Width of a pack id that indexes the tracker and the information store
    localparam int PACK_ID_BITS = 4;

    // The occupancy count needs one more bit to tell a full tracker from an empty one
    localparam int PACK_CNT_BITS = PACK_ID_BITS + 1;

endpackage

/* rtl/bru_types_pkg.sv */
/*
 * Branch-type encoding and bimodal counter type of the branch unit.
 * The store keeps both fields per pack and the resolver decodes them
 * to rebuild the prediction made at fetch.
 */

package bru_types_pkg;

    // Branch kind as classified by the decoder
    // Only conditional branches consult the bimodal counter
    typedef enum logic [1:0] {
        BT_COND = 2'b00,
        BT_JUMP = 2'b01,
        BT_CALL = 2'b10,
        BT_RET  = 2'b11
    } btype_t;

    // Two-bit saturating counter of the bimodal predictor
    // The encoding is ordered so that an increment moves toward taken
    typedef enum logic [1:0] {
        BM_STRONG_NT = 2'b00,
        BM_WEAK_NT   = 2'b01,
        BM_WEAK_T    = 2'b10,
        BM_STRONG_T  = 2'b11
    } bm_ctr_t;

    // The upper counter bit alone gives the predicted direction
    localparam int BM_TAKEN_BIT = 1;

endpackage

/* rtl/binfo.sv */
/*
 * Branch-information store holding the fetch-time prediction of every pack.
 * Rename writes a record at the freshly allocated pack id and the resolver
 * reads it back asynchronously when execute resolves that pack.
 */
`timescale 1ns/1ns

module binfo #(
    parameter int ENABLE_C_EXTENSION = 1,
    localparam int PC_BITS = ENABLE_C_EXTENSION == 1 ? 31 : 30,
    localparam int IDX_BITS = ENABLE_C_EXTENSION == 1 ? 2 : 1
) (
    input  logic                                   cpu_clock_i,

    input  logic                                   wr_en_i,
    input  logic [bru_cfg_pkg::PACK_ID_BITS-1:0]   wr_pack_i,
    input  logic [PC_BITS-1:0]                     wr_pc_i,
    input  bru_types_pkg::bm_ctr_t                 wr_bm_pred_i,
    input  bru_types_pkg::btype_t                  wr_btype_i,
    input  logic                                   wr_btb_vld_i,
    input  logic [PC_BITS-1:0]                     wr_btb_target_i,
    input  logic                                   wr_btb_way_i,
    input  logic [IDX_BITS-1:0]                    wr_btb_idx_i,

    input  logic [bru_cfg_pkg::PACK_ID_BITS-1:0]   rd_pack_i,
    output logic [PC_BITS-1:0]                     rd_pc_o,
    output bru_types_pkg::bm_ctr_t                 rd_bm_pred_o,
    output bru_types_pkg::btype_t                  rd_btype_o,
    output logic                                   rd_btb_vld_o,
    output logic [PC_BITS-1:0]                     rd_btb_target_o,
    output logic                                   rd_btb_way_o,
    output logic [IDX_BITS-1:0]                    rd_btb_idx_o
);
    import bru_cfg_pkg::*;
    import bru_types_pkg::*;

    // One array per field keeps the enum types intact on the way through
    logic [PC_BITS-1:0]  pc_mem         [PACK_COUNT];
    bm_ctr_t             bm_pred_mem    [PACK_COUNT];
    btype_t              btype_mem      [PACK_COUNT];
    logic                btb_vld_mem    [PACK_COUNT];
    logic [PC_BITS-1:0]  btb_target_mem [PACK_COUNT];
    logic                btb_way_mem    [PACK_COUNT];
    logic [IDX_BITS-1:0] btb_idx_mem    [PACK_COUNT]; 

    // The whole record lands on the allocation edge
    always_ff @(posedge cpu_clock_i) begin
        if (wr_en_i) begin
            pc_mem[wr_pack_i]         <= wr_pc_i;
            bm_pred_mem[wr_pack_i]    <= wr_bm_pred_i;
            btype_mem[wr_pack_i]      <= wr_btype_i;
            btb_vld_mem[wr_pack_i]    <= wr_btb_vld_i;
            btb_target_mem[wr_pack_i] <= wr_btb_target_i;
            btb_way_mem[wr_pack_i]    <= wr_btb_way_i;
            btb_idx_mem[wr_pack_i]    <= wr_btb_idx_i;
        end
    end

    // Reads are combinational so the resolver sees the record in the resolve cycle
    assign rd_pc_o         = pc_mem[rd_pack_i];
    assign rd_bm_pred_o    = bm_pred_mem[rd_pack_i];
    assign rd_btype_o      = btype_mem[rd_pack_i];
    assign rd_btb_vld_o    = btb_vld_mem[rd_pack_i];
    assign rd_btb_target_o = btb_target_mem[rd_pack_i];
    assign rd_btb_way_o    = btb_way_mem[rd_pack_i];
    assign rd_btb_idx_o    = btb_idx_mem[rd_pack_i];

endmodule

/* rtl/pack_tracker.sv */
/*
 * In-order allocator of branch pack ids.
 * Rename takes the id at the tail, resolution frees the head, and a
 * mispredict pulls the tail back to just past the mispredicted pack.
 */
`timescale 1ns/1ns

module pack_tracker (
    input  logic                                   cpu_clock_i,
    input  logic                                   rst_n_i,

    input  logic                                   alloc_valid_i,
    output logic                                   alloc_ready_o,
    output logic [bru_cfg_pkg::PACK_ID_BITS-1:0]   alloc_pack_o,
    output logic                                   wr_en_o,

    input  logic                                   release_i,
    input  logic                                   flush_i,
    input  logic [bru_cfg_pkg::PACK_ID_BITS-1:0]   flush_pack_i
);
    import bru_cfg_pkg::*;

    logic [PACK_ID_BITS-1:0]  head_q;
    logic [PACK_ID_BITS-1:0]  tail_q;
    logic [PACK_CNT_BITS-1:0] count_q;
    logic [PACK_ID_BITS-1:0]  head_nxt;
    logic [PACK_ID_BITS-1:0]  tail_nxt;
    logic                     full;
    logic                     do_release;

    assign full = (count_q == PACK_CNT_BITS'(PACK_COUNT));

    // No new pack is handed out while the younger ones are being dropped
    assign alloc_ready_o = !full && !flush_i;
    assign alloc_pack_o  = tail_q;
    assign wr_en_o       = alloc_valid_i && alloc_ready_o;

    // A release on an empty tracker is ignored so the count cannot underflow
    assign do_release = release_i && (count_q != '0);

    assign head_nxt = do_release ? head_q + 1'b1 : head_q;

    // On a flush the pack after the mispredicted one becomes the next to allocate
    always_comb begin
        if (flush_i) begin
            tail_nxt = flush_pack_i + 1'b1;
        end else if (wr_en_o) begin
            tail_nxt = tail_q + 1'b1;
        end else begin
            tail_nxt = tail_q;
        end
    end

    always_ff @(posedge cpu_clock_i) begin
        if (!rst_n_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            head_q <= head_nxt;
            tail_q <= tail_nxt;
            // After a flush the distance between the new pointers is the new count
            if (flush_i) begin
                count_q <= {1'b0, tail_nxt - head_nxt};
            end else begin
                count_q <= count_q + PACK_CNT_BITS'(wr_en_o) - PACK_CNT_BITS'(do_release);
            end
        end
    end

endmodule

/* rtl/branch_resolver.sv */
/*
 * Branch resolver comparing the executed outcome with the stored prediction.
 * It reads the information store at the resolved pack id and registers the
 * redirect, the bimodal counter update and the BTB update one cycle later.
 */
`timescale 1ns/1ns

module branch_resolver #(
    parameter int ENABLE_C_EXTENSION = 1,
    localparam int PC_BITS = ENABLE_C_EXTENSION == 1 ? 31 : 30,
    localparam int IDX_BITS = ENABLE_C_EXTENSION == 1 ? 2 : 1
) (
    input  logic                                   cpu_clock_i,
    input  logic                                   rst_n_i,

    input  logic                                   res_valid_i,
    input  logic [bru_cfg_pkg::PACK_ID_BITS-1:0]   res_pack_i,
    input  logic                                   res_taken_i,
    input  logic [PC_BITS-1:0]                     res_target_i,
    input  logic [PC_BITS-1:0]                     res_fallthrough_i,

    output logic [bru_cfg_pkg::PACK_ID_BITS-1:0]   rd_pack_o,
    input  logic [PC_BITS-1:0]                     rd_pc_i,
    input  bru_types_pkg::bm_ctr_t                 rd_bm_pred_i,
    input  bru_types_pkg::btype_t                  rd_btype_i,
    input  logic                                   rd_btb_vld_i,
    input  logic [PC_BITS-1:0]                     rd_btb_target_i,
    input  logic                                   rd_btb_way_i,
    input  logic [IDX_BITS-1:0]                    rd_btb_idx_i,

    output logic                                   redirect_valid_o,
    output logic [PC_BITS-1:0]                     redirect_pc_o,

    output logic                                   bm_upd_valid_o,
    output logic [PC_BITS-1:0]                     bm_upd_pc_o,
    output bru_types_pkg::bm_ctr_t                 bm_upd_ctr_o,

    output logic                                   btb_upd_valid_o,
    output logic [PC_BITS-1:0]                     btb_upd_pc_o,
    output logic [PC_BITS-1:0]                     btb_upd_target_o,
    output bru_types_pkg::btype_t                  btb_upd_btype_o,
    output logic                                   btb_upd_way_o,
    output logic [IDX_BITS-1:0]                    btb_upd_idx_o,

    output logic [bru_cfg_pkg::PACK_ID_BITS-1:0]   flush_pack_o
);
    import bru_types_pkg::*;

    logic    pred_taken;
    logic    target_wrong;
    logic    mispredict;
    logic    is_cond;
    logic    btb_fix;
    bm_ctr_t next_ctr;

    // The store is looked up at the pack that execute is resolving right now
    assign rd_pack_o = res_pack_i;

    assign is_cond = (rd_btype_i == BT_COND);

    // Fetch only followed a branch that hit in the BTB
    // Conditional ones were further steered by the counter direction bit
    assign pred_taken = rd_btb_vld_i && (!is_cond || rd_bm_pred_i[BM_TAKEN_BIT]);

    assign target_wrong = (rd_btb_target_i != res_target_i);

    // Wrong direction, or right direction but fetch went to the wrong place
    assign mispredict = (pred_taken != res_taken_i) ||
                        (pred_taken && res_taken_i && target_wrong);

    // Taken branches teach the BTB when it missed or pointed elsewhere
    assign btb_fix = res_taken_i && (!rd_btb_vld_i || target_wrong);

    // Saturating step of the bimodal counter toward the resolved direction
    always_comb begin
        if (res_taken_i) begin
            next_ctr = (rd_bm_pred_i == BM_STRONG_T) ? BM_STRONG_T
                                                     : bm_ctr_t'(rd_bm_pred_i + 2'd1);
        end else begin
            next_ctr = (rd_bm_pred_i == BM_STRONG_NT) ? BM_STRONG_NT
                                                      : bm_ctr_t'(rd_bm_pred_i - 2'd1);
        end
    end

    // Result strobes last exactly one cycle after each resolution
    always_ff @(posedge cpu_clock_i) begin
        if (!rst_n_i) begin
            redirect_valid_o <= 1'b0;
            bm_upd_valid_o   <= 1'b0;
            btb_upd_valid_o  <= 1'b0;
        end else begin
            redirect_valid_o <= res_valid_i && mispredict;
            bm_upd_valid_o   <= res_valid_i && is_cond;
            btb_upd_valid_o  <= res_valid_i && btb_fix;
        end
    end

    // Payload is captured on every resolution and qualified by the strobes above
    always_ff @(posedge cpu_clock_i) begin
        if (res_valid_i) begin
            redirect_pc_o    <= res_taken_i ? res_target_i : res_fallthrough_i;
            bm_upd_pc_o      <= rd_pc_i;
            bm_upd_ctr_o     <= next_ctr;
            btb_upd_pc_o     <= rd_pc_i;
            btb_upd_target_o <= res_target_i;
            btb_upd_btype_o  <= rd_btype_i;
            btb_upd_way_o    <= rd_btb_way_i;
            btb_upd_idx_o    <= rd_btb_idx_i;
        end
    end

    // The tracker needs the mispredicted id in the cycle the redirect is raised
    always_ff @(posedge cpu_clock_i) begin
        if (res_valid_i && mispredict) begin
            flush_pack_o <= res_pack_i;
        end
    end

endmodule

/* rtl/branch_unit_top.sv */
/*
 * Branch-information side of the branch unit.
 * Rename allocates a pack and stores its prediction, execute resolves the pack
 * and the unit returns redirect, bimodal and BTB updates one cycle later.
 */
`timescale 1ns/1ns

module branch_unit_top #(
    parameter int ENABLE_C_EXTENSION = 1,
    localparam int PC_BITS = ENABLE_C_EXTENSION == 1 ? 31 : 30,
    localparam int IDX_BITS = ENABLE_C_EXTENSION == 1 ? 2 : 1
) (
    input  logic                                   cpu_clock_i,
    input  logic                                   rst_n_i,

    // Allocation from rename
    input  logic                                   alloc_valid_i,
    output logic                                   alloc_ready_o,
    output logic [bru_cfg_pkg::PACK_ID_BITS-1:0]   alloc_pack_o,
    input  logic [PC_BITS-1:0]                     rn_pc_i,
    input  bru_types_pkg::bm_ctr_t                 rn_bm_pred_i,
    input  bru_types_pkg::btype_t                  rn_btype_i,
    input  logic                                   rn_btb_vld_i,
    input  logic [PC_BITS-1:0]                     rn_btb_target_i,
    input  logic                                   rn_btb_way_i,
    input  logic [IDX_BITS-1:0]                    rn_btb_idx_i,

    // Resolution from execute
    input  logic                                   res_valid_i,
    input  logic [bru_cfg_pkg::PACK_ID_BITS-1:0]   res_pack_i,
    input  logic                                   res_taken_i,
    input  logic [PC_BITS-1:0]                     res_target_i,
    input  logic [PC_BITS-1:0]                     res_fallthrough_i,

    // Results toward fetch, the bimodal table and the BTB
    output logic                                   redirect_valid_o,
    output logic [PC_BITS-1:0]                     redirect_pc_o,
    output logic                                   bm_upd_valid_o,
    output logic [PC_BITS-1:0]                     bm_upd_pc_o,
    output bru_types_pkg::bm_ctr_t                 bm_upd_ctr_o,
    output logic                                   btb_upd_valid_o,
    output logic [PC_BITS-1:0]                     btb_upd_pc_o,
    output logic [PC_BITS-1:0]                     btb_upd_target_o,
    output bru_types_pkg::btype_t                  btb_upd_btype_o,
    output logic                                   btb_upd_way_o,
    output logic [IDX_BITS-1:0]                    btb_upd_idx_o
);
    import bru_cfg_pkg::*;
    import bru_types_pkg::*;

    logic                    wr_en;
    logic [PACK_ID_BITS-1:0] rd_pack;
    logic [PACK_ID_BITS-1:0] flush_pack;
    logic [PC_BITS-1:0]      rd_pc;
    bm_ctr_t                 rd_bm_pred;
    btype_t                  rd_btype;
    logic                    rd_btb_vld;
    logic [PC_BITS-1:0]      rd_btb_target;
    logic                    rd_btb_way;
    logic [IDX_BITS-1:0]     rd_btb_idx;

    // Each resolution frees the oldest pack and a redirect flushes the younger ones
    pack_tracker u_tracker (
        .cpu_clock_i   (cpu_clock_i),
        .rst_n_i       (rst_n_i),
        .alloc_valid_i (alloc_valid_i),
        .alloc_ready_o (alloc_ready_o),
        .alloc_pack_o  (alloc_pack_o),
        .wr_en_o       (wr_en),
        .release_i     (res_valid_i),
        .flush_i       (redirect_valid_o),
        .flush_pack_i  (flush_pack)
    );

    binfo #(.ENABLE_C_EXTENSION(ENABLE_C_EXTENSION)) u_binfo (
        .cpu_clock_i     (cpu_clock_i),
        .wr_en_i         (wr_en),
        .wr_pack_i       (alloc_pack_o),
        .wr_pc_i         (rn_pc_i),
        .wr_bm_pred_i    (rn_bm_pred_i),
        .wr_btype_i      (rn_btype_i),
        .wr_btb_vld_i    (rn_btb_vld_i),
        .wr_btb_target_i (rn_btb_target_i),
        .wr_btb_way_i    (rn_btb_way_i),
        .wr_btb_idx_i    (rn_btb_idx_i),
        .rd_pack_i       (rd_pack),
        .rd_pc_o         (rd_pc),
        .rd_bm_pred_o    (rd_bm_pred),
        .rd_btype_o      (rd_btype),
        .rd_btb_vld_o    (rd_btb_vld),
        .rd_btb_target_o (rd_btb_target),
        .rd_btb_way_o    (rd_btb_way),
        .rd_btb_idx_o    (rd_btb_idx)
    );

    branch_resolver #(.ENABLE_C_EXTENSION(ENABLE_C_EXTENSION)) u_resolver (
        .cpu_clock_i       (cpu_clock_i),
        .rst_n_i           (rst_n_i),
        .res_valid_i       (res_valid_i),
        .res_pack_i        (res_pack_i),
        .res_taken_i       (res_taken_i),
        .res_target_i      (res_target_i),
        .res_fallthrough_i (res_fallthrough_i),
        .rd_pack_o         (rd_pack),
        .rd_pc_i           (rd_pc),
        .rd_bm_pred_i      (rd_bm_pred),
        .rd_btype_i        (rd_btype),
        .rd_btb_vld_i      (rd_btb_vld),
        .rd_btb_target_i   (rd_btb_target),
        .rd_btb_way_i      (rd_btb_way),
        .rd_btb_idx_i      (rd_btb_idx),
        .redirect_valid_o  (redirect_valid_o),
        .redirect_pc_o     (redirect_pc_o),
        .bm_upd_valid_o    (bm_upd_valid_o),
        .bm_upd_pc_o       (bm_upd_pc_o),
        .bm_upd_ctr_o      (bm_upd_ctr_o),
        .btb_upd_valid_o   (btb_upd_valid_o),
        .btb_upd_pc_o      (btb_upd_pc_o),
        .btb_upd_target_o  (btb_upd_target_o),
        .btb_upd_btype_o   (btb_upd_btype_o),
        .btb_upd_way_o     (btb_upd_way_o),
        .btb_upd_idx_o     (btb_upd_idx_o),
        .flush_pack_o      (flush_pack)
    );

endmodule

/* verif/branch_unit_assertions.sv */
/*
 * Concurrent checks on the branch unit top level, attached by bind
 * Covers the redirect pulse length, the allocation stall during a flush
 * and the result strobes right after reset
 */
`timescale 1ns/1ns

module branch_unit_assertions (
    input logic cpu_clock_i,
    input logic rst_n_i,
    input logic alloc_ready_i,
    input logic redirect_valid_i,
    input logic bm_upd_valid_i,
    input logic btb_upd_valid_i
);

    // A redirect is a single-cycle pulse per resolution
    redirect_one_cycle: assert property (
        @(posedge cpu_clock_i) disable iff (!rst_n_i)
        redirect_valid_i |=> !redirect_valid_i
    ) else $error("redirect_valid_o stayed high for more than one cycle");

    // The tracker refuses new packs while it rewinds the tail
    no_alloc_in_flush: assert property (
        @(posedge cpu_clock_i) disable iff (!rst_n_i)
        redirect_valid_i |-> !alloc_ready_i
    ) else $error("alloc_ready_o high during a redirect");

    // Every result strobe is cleared by a reset edge
    valids_low_after_reset: assert property (
        @(posedge cpu_clock_i)
        !rst_n_i |=> (!redirect_valid_i && !bm_upd_valid_i && !btb_upd_valid_i)
    ) else $error("result valid high in the cycle after reset");

endmodule

bind branch_unit_top branch_unit_assertions u_assertions (
    .cpu_clock_i      (cpu_clock_i),
    .rst_n_i          (rst_n_i),
    .alloc_ready_i    (alloc_ready_o),
    .redirect_valid_i (redirect_valid_o),
    .bm_upd_valid_i   (bm_upd_valid_o),
    .btb_upd_valid_i  (btb_upd_valid_o)
);

/* verif/branch_unit_tb.sv */
/*
 * Testbench for the branch unit top level
 * A table of prediction records and outcomes is allocated and resolved in a loop,
 * followed by the reset, full-tracker and mispredict-flush scenarios
 */
`timescale 1ns/1ns

module branch_unit_tb;
    import bru_cfg_pkg::*;
    import bru_types_pkg::*;

    localparam int C_EXT = 1;
    localparam int PC_BITS = C_EXT == 1 ? 31 : 30;
    localparam int IDX_BITS = C_EXT == 1 ? 2 : 1;
    localparam int NUM_ROWS = 12;
    localparam int READY_TIMEOUT = 50;

    // DUT ports, named as on the top level so the instance can use .*
    logic                    cpu_clock_i;
    logic                    rst_n_i;
    logic                    alloc_valid_i;
    logic                    alloc_ready_o;
    logic [PACK_ID_BITS-1:0] alloc_pack_o;
    logic [PC_BITS-1:0]      rn_pc_i;
    bm_ctr_t                 rn_bm_pred_i;
    btype_t                  rn_btype_i;
    logic                    rn_btb_vld_i;
    logic [PC_BITS-1:0]      rn_btb_target_i;
    logic                    rn_btb_way_i;
    logic [IDX_BITS-1:0]     rn_btb_idx_i;
    logic                    res_valid_i;
    logic [PACK_ID_BITS-1:0] res_pack_i;
    logic                    res_taken_i;
    logic [PC_BITS-1:0]      res_target_i;
    logic [PC_BITS-1:0]      res_fallthrough_i;
    logic                    redirect_valid_o;
    logic [PC_BITS-1:0]      redirect_pc_o;
    logic                    bm_upd_valid_o;
    logic [PC_BITS-1:0]      bm_upd_pc_o;
    bm_ctr_t                 bm_upd_ctr_o;
    logic                    btb_upd_valid_o;
    logic [PC_BITS-1:0]      btb_upd_pc_o;
    logic [PC_BITS-1:0]      btb_upd_target_o;
    btype_t                  btb_upd_btype_o;
    logic                    btb_upd_way_o;
    logic [IDX_BITS-1:0]     btb_upd_idx_o;

    // One stored prediction, its resolved outcome and the expected results
    typedef struct {
        btype_t              btype;
        bm_ctr_t             ctr;
        logic                btb_vld;
        logic [PC_BITS-1:0]  pc;
        logic [PC_BITS-1:0]  btb_target;
        logic                way;
        logic [IDX_BITS-1:0] idx;
        logic                taken;
        logic [PC_BITS-1:0]  target;
        logic [PC_BITS-1:0]  fallthrough;
        logic                exp_redirect;
        logic [PC_BITS-1:0]  exp_redirect_pc;
        logic                exp_bm;
        bm_ctr_t             exp_ctr;
        logic                exp_btb;
    } row_t;

    row_t                    rows [NUM_ROWS];
    logic [15:0]             lfsr_state = 16'd8;
    logic [PACK_ID_BITS-1:0] exp_head;
    logic [PACK_ID_BITS-1:0] exp_tail;
    int                      errors;
    int                      checks;
    int                      test_num;
    int                      test_errs;

    branch_unit_top #(.ENABLE_C_EXTENSION(C_EXT)) uut (.*);

    initial begin
        cpu_clock_i = 1'b0;
        forever #10 cpu_clock_i = ~cpu_clock_i;
    end

    // Galois LFSR with taps 0xB400, one step per bit handed out
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        logic        b;
        val = '0;
        for (int i = 0; i < n; i++) begin
            b = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (b) begin
                lfsr_state = lfsr_state ^ 16'hB400;
            end
            val = {val[30:0], b};
        end
        return val;
    endfunction

    // Builds one row and works out its results from the resolution rules
    task automatic fill_row(input int i, input btype_t bt, input bm_ctr_t ctr,
                            input logic vld, input logic tgt_ok, input logic taken);
        logic pred_taken;
        logic tgt_diff;
        int   level;
        rows[i].btype       = bt;
        rows[i].ctr         = ctr;
        rows[i].btb_vld     = vld;
        rows[i].taken       = taken;
        rows[i].pc          = PC_BITS'(rand_bits(PC_BITS));
        rows[i].target      = PC_BITS'(rand_bits(PC_BITS));
        rows[i].btb_target  = tgt_ok ? rows[i].target : ~rows[i].target;
        rows[i].fallthrough = rows[i].pc + PC_BITS'(4);
        rows[i].way         = 1'(rand_bits(1));
        rows[i].idx         = IDX_BITS'(rand_bits(IDX_BITS));
        tgt_diff = (rows[i].btb_target != rows[i].target);
        // Fetch went taken only on a BTB hit, steered by the counter for conditionals
        pred_taken = vld && ((bt != BT_COND) || (ctr >= BM_WEAK_T));
        rows[i].exp_redirect    = (pred_taken != taken) || (pred_taken && taken && tgt_diff);
        rows[i].exp_redirect_pc = taken ? rows[i].target : rows[i].fallthrough;
        rows[i].exp_bm          = (bt == BT_COND);
        rows[i].exp_btb         = taken && (!vld || tgt_diff);
        // Counter level moves one step toward the outcome and clamps at 0 and 3
        level = int'(ctr) + (taken ? 1 : -1);
        if (level > 3) begin
            level = 3;
        end
        if (level < 0) begin
            level = 0;
        end
        rows[i].exp_ctr = bm_ctr_t'(level[1:0]);
    endtask

    task automatic build_table();
        // Correct conditionals, including saturation at both ends
        fill_row(0, BT_COND, BM_WEAK_T, 1'b1, 1'b1, 1'b1);
        fill_row(1, BT_COND, BM_STRONG_T, 1'b1, 1'b1, 1'b1);
        fill_row(2, BT_COND, BM_WEAK_NT, 1'b1, 1'b1, 1'b0);
        fill_row(3, BT_COND, BM_STRONG_NT, 1'b0, 1'b1, 1'b0);
        // Direction mispredicts in both directions
        fill_row(4, BT_COND, BM_WEAK_NT, 1'b1, 1'b1, 1'b1);
        fill_row(5, BT_COND, BM_STRONG_T, 1'b1, 1'b1, 1'b0);
        fill_row(6, BT_COND, BM_WEAK_T, 1'b0, 1'b1, 1'b1);
        // Unconditional kinds with a correct hit, a miss and wrong targets
        fill_row(7, BT_JUMP, BM_WEAK_NT, 1'b1, 1'b1, 1'b1);
        fill_row(8, BT_JUMP, BM_STRONG_NT, 1'b0, 1'b1, 1'b1);
        fill_row(9, BT_CALL, BM_WEAK_T, 1'b1, 1'b0, 1'b1);
        fill_row(10, BT_RET, BM_STRONG_NT, 1'b1, 1'b0, 1'b1);
        fill_row(11, BT_COND, BM_STRONG_T, 1'b1, 1'b0, 1'b1);
    endtask

    // Inputs change 2 ns after the rising edge, away from the DUT's sampling
    task automatic step();
        @(posedge cpu_clock_i);
        #2;
    endtask

    task automatic mismatch(input string msg);
        errors++;
        $display("MISMATCH at %0t ns: %s", $time, msg);
    endtask

    task automatic print_counts();
        $display("tests: %0d, checks: %0d, errors: %0d", test_num, checks, errors);
    endtask

    task automatic end_test(input string name);
        test_num++;
        $display("test %0d %s: %0d new errors", test_num, name, errors - test_errs);
        test_errs = errors;
    endtask

    task automatic check_redirect(input string tag, input logic exp_valid,
                                  input logic [PC_BITS-1:0] exp_pc);
        checks++;
        if (redirect_valid_o !== exp_valid) begin
            mismatch($sformatf("%s redirect_valid_o=%b expected %b",
                               tag, redirect_valid_o, exp_valid));
        end else if (exp_valid && redirect_pc_o !== exp_pc) begin
            mismatch($sformatf("%s redirect_pc_o=%h expected %h", tag, redirect_pc_o, exp_pc));
        end
    endtask

    task automatic check_bm_update(input string tag, input logic exp_valid,
                                   input logic [PC_BITS-1:0] exp_pc, input bm_ctr_t exp_ctr);
        checks++;
        if (bm_upd_valid_o !== exp_valid) begin
            mismatch($sformatf("%s bm_upd_valid_o=%b expected %b",
                               tag, bm_upd_valid_o, exp_valid));
        end else if (exp_valid && (bm_upd_pc_o !== exp_pc || bm_upd_ctr_o !== exp_ctr)) begin
            mismatch($sformatf("%s bimodal update pc=%h ctr=%0d expected pc=%h ctr=%0d",
                               tag, bm_upd_pc_o, bm_upd_ctr_o, exp_pc, exp_ctr));
        end
    endtask

    task automatic check_btb_update(input string tag, input logic exp_valid,
                                    input logic [PC_BITS-1:0] exp_pc,
                                    input logic [PC_BITS-1:0] exp_target,
                                    input btype_t exp_btype, input logic exp_way,
                                    input logic [IDX_BITS-1:0] exp_idx);
        checks++;
        if (btb_upd_valid_o !== exp_valid) begin
            mismatch($sformatf("%s btb_upd_valid_o=%b expected %b",
                               tag, btb_upd_valid_o, exp_valid));
        end else if (exp_valid && (btb_upd_pc_o !== exp_pc || btb_upd_target_o !== exp_target ||
                     btb_upd_btype_o !== exp_btype || btb_upd_way_o !== exp_way ||
                     btb_upd_idx_o !== exp_idx)) begin
            mismatch($sformatf("%s BTB update pc=%h tgt=%h type=%0d way=%b idx=%0d", tag,
                               btb_upd_pc_o, btb_upd_target_o, btb_upd_btype_o,
                               btb_upd_way_o, btb_upd_idx_o));
        end
    endtask

    task automatic check_alloc(input string tag, input logic exp_ready,
                               input logic [PACK_ID_BITS-1:0] exp_pack);
        checks++;
        if (alloc_ready_o !== exp_ready || alloc_pack_o !== exp_pack) begin
            mismatch($sformatf("%s alloc ready=%b pack=%0d expected ready=%b pack=%0d",
                               tag, alloc_ready_o, alloc_pack_o, exp_ready, exp_pack));
        end
    endtask

    task automatic wait_ready();
        int tries;
        tries = 0;
        while (!alloc_ready_o && tries < READY_TIMEOUT) begin
            step();
            tries++;
        end
        if (!alloc_ready_o) begin
            errors++;
            $display("ERROR at %0t ns: allocation never became ready", $time);
            print_counts();
            $display("test failed");
            $finish;
        end
    endtask

    task automatic drive_record(input int r);
        rn_pc_i         = rows[r].pc;
        rn_bm_pred_i    = rows[r].ctr;
        rn_btype_i      = rows[r].btype;
        rn_btb_vld_i    = rows[r].btb_vld;
        rn_btb_target_i = rows[r].btb_target;
        rn_btb_way_i    = rows[r].way;
        rn_btb_idx_i    = rows[r].idx;
    endtask

    // Hands the record of row r to rename and checks the id it receives
    task automatic alloc_row(input int r);
        wait_ready();
        check_alloc($sformatf("alloc row %0d", r), 1'b1, exp_tail);
        drive_record(r);
        alloc_valid_i = 1'b1;
        step();
        alloc_valid_i = 1'b0;
        exp_tail = exp_tail + 1'b1;
    endtask

    // Resolves the oldest pack with the outcome of row r, results come one cycle later
    task automatic resolve_row(input int r);
        string tag;
        tag = $sformatf("row %0d pack %0d", r, exp_head);
        res_valid_i       = 1'b1;
        res_pack_i        = exp_head;
        res_taken_i       = rows[r].taken;
        res_target_i      = rows[r].target;
        res_fallthrough_i = rows[r].fallthrough;
        step();
        res_valid_i = 1'b0;
        check_redirect(tag, rows[r].exp_redirect, rows[r].exp_redirect_pc);
        check_bm_update(tag, rows[r].exp_bm, rows[r].pc, rows[r].exp_ctr);
        check_btb_update(tag, rows[r].exp_btb, rows[r].pc, rows[r].target, rows[r].btype,
                         rows[r].way, rows[r].idx);
        // Allocation stalls while the younger packs are dropped
        if (rows[r].exp_redirect) begin
            check_alloc(tag, 1'b0, exp_tail);
            exp_tail = exp_head + 1'b1;
        end
        exp_head = exp_head + 1'b1;
    endtask

    initial begin
        rst_n_i = 1'b0;
        alloc_valid_i = 1'b0;
        res_valid_i = 1'b0;
        res_pack_i = '0;
        res_taken_i = 1'b0;
        res_target_i = '0;
        res_fallthrough_i = '0;
        build_table();
        drive_record(0);
        errors = 0;
        checks = 0;
        test_num = 0;
        test_errs = 0;
        exp_head = '0;
        exp_tail = '0;
        repeat (3) step();
        rst_n_i = 1'b1;

        // Reset state, then ids 0, 1, 2 in order
        check_redirect("reset", 1'b0, '0);
        check_bm_update("reset", 1'b0, '0, BM_STRONG_NT);
        check_btb_update("reset", 1'b0, '0, '0, BT_COND, 1'b0, '0);
        check_alloc("reset", 1'b1, '0);
        for (int i = 0; i < 3; i++) begin
            alloc_row(7);
        end
        for (int i = 0; i < 3; i++) begin
            resolve_row(7);
        end
        end_test("reset and in-order ids");

        for (int r = 0; r < NUM_ROWS; r++) begin
            alloc_row(r);
            resolve_row(r);
            end_test($sformatf("table row %0d %s", r, rows[r].btype.name()));
        end

        // Fill all packs, then a blocked request must not write or advance
        for (int i = 0; i < PACK_COUNT; i++) begin
            alloc_row(7);
        end
        check_alloc("full", 1'b0, exp_tail);
        drive_record(0);
        alloc_valid_i = 1'b1;
        repeat (2) begin
            step();
            check_alloc("full blocked", 1'b0, exp_tail);
        end
        alloc_valid_i = 1'b0;
        resolve_row(7);
        check_alloc("after release", 1'b1, exp_tail);
        alloc_row(7);
        check_alloc("full again", 1'b0, exp_tail);
        for (int i = 0; i < PACK_COUNT; i++) begin
            resolve_row(7);
        end
        end_test("full tracker back-pressure");

        // Mispredict on the middle pack, the youngest id is reused with a new record
        alloc_row(7);
        alloc_row(4);
        alloc_row(0);
        resolve_row(7);
        resolve_row(4);
        alloc_row(8);
        resolve_row(8);
        end_test("mispredict flush");

        print_counts();
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* tb.f */
rtl/bru_cfg_pkg.sv
rtl/bru_types_pkg.sv
rtl/binfo.sv
rtl/pack_tracker.sv
rtl/branch_resolver.sv
rtl/branch_unit_top.sv
verif/branch_unit_assertions.sv
verif/branch_unit_tb.sv

/* Makefile */
# Verilator build of the branch unit testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= branch_unit_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# The run fails unless the simulation prints the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

clean:
	rm -rf $(OBJ_DIR)
